//--- verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

    // Machine word and register index widths
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    // Six-bit opcodes in instruction bits 31:26
    // Values outside this list decode as a no-operation
    typedef enum logic [5:0] {
        ADD   = 6'd0,
        ADDI  = 6'd1,
        SUB   = 6'd2,
        SUBI  = 6'd3,
        AND   = 6'd8,
        OR    = 6'd9,
        BEQZ  = 6'd11,
        BNEQZ = 6'd12,
        LW    = 6'd13,
        SW    = 6'd14,
        SLT   = 6'd15,
        SLTI  = 6'd16,
        HLT   = 6'd63
    } opcodeT;

    // Instruction classes steer the later stages
    typedef enum logic [2:0] {
        RR_ALU = 3'b000,
        RI_ALU = 3'b010,
        LOAD   = 3'b011,
        STORE  = 3'b100,
        BRANCH = 3'b101,
        NOP    = 3'b110,
        HALT   = 3'b111
    } instrClassT;

    // IF/ID register contents
    typedef struct packed {
        wordT instr;
        wordT npc;
    } ifIdT;

    // ID/EX register contents
    typedef struct packed {
        instrClassT cls;
        opcodeT opcode;
        regAddrT rs;
        regAddrT rt;
        regAddrT dest;
        logic regWrite;
        logic memWrite;
        wordT opA;
        wordT opB;
        wordT imm;
        wordT npc;
    } idExT;

    // EX/MEM register contents
    typedef struct packed {
        instrClassT cls;
        regAddrT dest;
        logic regWrite;
        logic memWrite;
        wordT result;
        wordT storeData;
    } exMemT;

    // Register file write, also the MEM/WB forwarding source
    typedef struct packed {
        logic we;
        regAddrT dest;
        wordT data;
    } wbWriteT;

    // Opcode 62 is unassigned, so this word decodes as a no-operation
    localparam wordT bubbleInstr = 32'hF800_0000;

    localparam ifIdT ifIdBubble = '{instr: bubbleInstr, npc: '0};

    localparam idExT idExBubble = '{
        cls: NOP, opcode: ADD, rs: '0, rt: '0, dest: '0, regWrite: 1'b0,
        memWrite: 1'b0, opA: '0, opB: '0, imm: '0, npc: '0
    };

    localparam exMemT exMemBubble = '{
        cls: NOP, dest: '0, regWrite: 1'b0, memWrite: 1'b0, result: '0, storeData: '0
    };

endpackage

`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter int memWords = 1024
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 halted,
    input  logic                 stall,
    input  logic                 redirect,
    input  mipsPkg::wordT        redirectTarget,
    output mipsPkg::wordT        instrAddr,
    input  mipsPkg::wordT        instrData,
    output mipsPkg::ifIdT        ifId
);

    localparam int addrBits = $clog2(memWords);

    mipsPkg::wordT pc;
    mipsPkg::wordT pcNext;
    mipsPkg::wordT target;

    // The PC wraps inside the memory so it never points past the last word
    assign pcNext = mipsPkg::wordT'(pc[addrBits-1:0] + 1'b1);
    assign target = mipsPkg::wordT'(redirectTarget[addrBits-1:0]);
    assign instrAddr = pc;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
            ifId <= mipsPkg::ifIdBubble;
        end else if (!halted) begin
            if (redirect) begin
                // Taken branch in EX, the word being fetched now is on the wrong path
                pc <= target;
                ifId <= mipsPkg::ifIdBubble;
            end else if (!stall) begin
                pc <= pcNext;
                ifId <= '{instr: instrData, npc: pcNext};
            end
            // Under stall both PC and IF/ID keep the instruction waiting on the load
        end
    end

    // Once the core halts the instruction stream is frozen
    pcFrozenWhenHalted: assert property (@(posedge clock) disable iff (rst)
        halted |=> $stable(pc));

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                 clock,
    input  logic                 rst,
    input  mipsPkg::regAddrT     rsAddr,
    input  mipsPkg::regAddrT     rtAddr,
    output mipsPkg::wordT        rsData,
    output mipsPkg::wordT        rtData,
    input  mipsPkg::wbWriteT     wbWrite
);

    localparam int numRegs = 2 ** mipsPkg::regAddrWidth;

    mipsPkg::wordT regs [numRegs];

    // Registers start at zero so the architectural state is defined after reset
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWrite.we) begin
            regs[wbWrite.dest] <= wbWrite.data;
        end
    end

    // r0 always reads zero
    // A write landing this cycle is passed straight to the reader
    assign rsData = (rsAddr == '0) ? '0 :
                    (wbWrite.we && wbWrite.dest == rsAddr) ? wbWrite.data : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (wbWrite.we && wbWrite.dest == rtAddr) ? wbWrite.data : regs[rtAddr];

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 halted,
    input  logic                 redirect,
    input  mipsPkg::ifIdT        ifId,
    output mipsPkg::regAddrT     rsAddr,
    output mipsPkg::regAddrT     rtAddr,
    input  mipsPkg::wordT        rsData,
    input  mipsPkg::wordT        rtData,
    output logic                 stall,
    output mipsPkg::idExT        idEx
);

    mipsPkg::opcodeT opcode;
    mipsPkg::instrClassT cls;
    mipsPkg::regAddrT rd;
    mipsPkg::regAddrT dest;
    logic regWrite;
    logic memWrite;
    logic haltSeen;

    // Field layout: opcode 31:26, rs 25:21, rt 20:16, rd 15:11, immediate 15:0
    assign opcode = mipsPkg::opcodeT'(ifId.instr[31:26]);
    assign rsAddr = ifId.instr[25:21];
    assign rtAddr = ifId.instr[20:16];
    assign rd = ifId.instr[15:11];

    always_comb begin
        cls = mipsPkg::NOP;
        dest = '0;
        regWrite = 1'b0;
        memWrite = 1'b0;
        case (opcode)
            mipsPkg::ADD, mipsPkg::SUB, mipsPkg::AND, mipsPkg::OR, mipsPkg::SLT: begin
                cls = mipsPkg::RR_ALU;
                dest = rd;
                regWrite = 1'b1;
            end
            mipsPkg::ADDI, mipsPkg::SUBI, mipsPkg::SLTI: begin
                cls = mipsPkg::RI_ALU;
                dest = rtAddr;
                regWrite = 1'b1;
            end
            mipsPkg::LW: begin
                cls = mipsPkg::LOAD;
                dest = rtAddr;
                regWrite = 1'b1;
            end
            mipsPkg::SW: begin
                cls = mipsPkg::STORE;
                memWrite = 1'b1;
            end
            mipsPkg::BEQZ, mipsPkg::BNEQZ: cls = mipsPkg::BRANCH;
            mipsPkg::HLT: cls = mipsPkg::HALT;
            default: cls = mipsPkg::NOP;
        endcase
        // A write to r0 is dropped here, so later stages never forward it
        if (dest == '0) begin
            regWrite = 1'b0;
        end
    end

    // The load result is not ready until MEM/WB, one cycle too late for EX
    assign stall = idEx.cls == mipsPkg::LOAD && idEx.regWrite &&
                   (idEx.dest == rsAddr || idEx.dest == rtAddr);

    always_ff @(posedge clock) begin
        if (rst) begin
            idEx <= mipsPkg::idExBubble;
            haltSeen <= 1'b0;
        end else if (!halted) begin
            // Redirect has priority, the instruction here is on the wrong path
            if (redirect || stall || haltSeen) begin
                idEx <= mipsPkg::idExBubble;
            end else begin
                idEx <= '{
                    cls: cls, opcode: opcode, rs: rsAddr, rt: rtAddr, dest: dest,
                    regWrite: regWrite, memWrite: memWrite, opA: rsData, opB: rtData,
                    imm: {{16{ifId.instr[15]}}, ifId.instr[15:0]}, npc: ifId.npc
                };
            end
            // Everything behind a HLT that really issued is dropped
            if (!redirect && !stall && cls == mipsPkg::HALT) begin
                haltSeen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 halted,
    input  mipsPkg::idExT        idEx,
    input  mipsPkg::wbWriteT     wbWrite,
    output logic                 redirect,
    output mipsPkg::wordT        redirectTarget,
    output mipsPkg::exMemT       exMem
);

    mipsPkg::wordT fwdA;
    mipsPkg::wordT fwdB;
    mipsPkg::wordT aluResult;

    // EX/MEM wins over MEM/WB, which wins over the value read in decode
    // A load in EX/MEM has no data yet and the decode stall keeps its users back
    function automatic mipsPkg::wordT forwardOperand(
        input mipsPkg::regAddrT src,
        input mipsPkg::wordT regValue
    );
        if (exMem.regWrite && exMem.cls != mipsPkg::LOAD && exMem.dest == src) begin
            return exMem.result;
        end
        if (wbWrite.we && wbWrite.dest == src) begin
            return wbWrite.data;
        end
        return regValue;
    endfunction

    always_comb begin
        fwdA = forwardOperand(idEx.rs, idEx.opA);
        fwdB = forwardOperand(idEx.rt, idEx.opB);
    end

    always_comb begin
        case (idEx.opcode)
            mipsPkg::ADD:   aluResult = fwdA + fwdB;
            mipsPkg::SUB:   aluResult = fwdA - fwdB;
            mipsPkg::AND:   aluResult = fwdA & fwdB;
            mipsPkg::OR:    aluResult = fwdA | fwdB;
            mipsPkg::SLT:   aluResult = mipsPkg::wordT'($signed(fwdA) < $signed(fwdB));
            mipsPkg::ADDI:  aluResult = fwdA + idEx.imm;
            mipsPkg::SUBI:  aluResult = fwdA - idEx.imm;
            mipsPkg::SLTI:  aluResult = mipsPkg::wordT'($signed(fwdA) < $signed(idEx.imm));
            // Effective address for both loads and stores
            mipsPkg::LW, mipsPkg::SW: aluResult = fwdA + idEx.imm;
            // npc already holds branch address + 1
            mipsPkg::BEQZ, mipsPkg::BNEQZ: aluResult = idEx.npc + idEx.imm;
            default:        aluResult = '0;
        endcase
    end

    // Branches test the forwarded rs against zero
    assign redirect = idEx.cls == mipsPkg::BRANCH &&
                      ((idEx.opcode == mipsPkg::BEQZ) == (fwdA == '0));
    // For a branch the ALU result is the target address
    assign redirectTarget = aluResult;

    always_ff @(posedge clock) begin
        if (rst) begin
            exMem <= mipsPkg::exMemBubble;
        end else if (!halted) begin
            // A taken branch has done its work and continues as a bubble
            if (redirect) begin
                exMem <= mipsPkg::exMemBubble;
            end else begin
                exMem <= '{
                    cls: idEx.cls, dest: idEx.dest, regWrite: idEx.regWrite,
                    memWrite: idEx.memWrite, result: aluResult, storeData: fwdB
                };
            end
        end
    end

    // The class set in decode must agree with the opcode that reaches the ALU
    rrOpcodeMatches: assert property (@(posedge clock) disable iff (rst)
        idEx.cls == mipsPkg::RR_ALU |-> idEx.opcode inside
            {mipsPkg::ADD, mipsPkg::SUB, mipsPkg::AND, mipsPkg::OR, mipsPkg::SLT});
    riOpcodeMatches: assert property (@(posedge clock) disable iff (rst)
        idEx.cls == mipsPkg::RI_ALU |-> idEx.opcode inside
            {mipsPkg::ADDI, mipsPkg::SUBI, mipsPkg::SLTI});

endmodule

`default_nettype wire

//--- verilog/memWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module memWriteback (
    input  logic                 clock,
    input  logic                 rst,
    input  mipsPkg::exMemT       exMem,
    output mipsPkg::wordT        dataAddr,
    output logic                 dataWrite,
    output mipsPkg::wordT        dataWdata,
    input  mipsPkg::wordT        dataRdata,
    output mipsPkg::wbWriteT     wbWrite,
    output logic                 halted
);

    // MEM/WB register, control part
    mipsPkg::instrClassT mwCls;
    mipsPkg::regAddrT mwDest;
    logic mwRegWrite;
    // MEM/WB register, payload part
    mipsPkg::wordT mwAluOut;
    mipsPkg::wordT mwLoadData;

    assign dataAddr = exMem.result;
    assign dataWdata = exMem.storeData;
    // Stores commit at the clock edge, never after the halt
    assign dataWrite = exMem.memWrite && !halted;

    always_ff @(posedge clock) begin
        if (rst) begin
            mwCls <= mipsPkg::NOP;
            mwDest <= '0;
            mwRegWrite <= 1'b0;
        end else if (!halted) begin
            mwCls <= exMem.cls;
            mwDest <= exMem.dest;
            mwRegWrite <= exMem.regWrite;
        end
    end

    always_ff @(posedge clock) begin
        if (!halted) begin
            mwAluOut <= exMem.result;
            mwLoadData <= dataRdata;
        end
    end

    // HLT raises halted as it leaves MEM/WB, after every older write is done
    always_ff @(posedge clock) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (mwCls == mipsPkg::HALT) begin
            halted <= 1'b1;
        end
    end

    assign wbWrite = '{
        we: mwRegWrite,
        dest: mwDest,
        data: (mwCls == mipsPkg::LOAD) ? mwLoadData : mwAluOut
    };

    haltedHoldsUntilReset: assert property (@(posedge clock)
        $fell(halted) |-> $past(rst));

endmodule

`default_nettype wire

//--- verilog/unifiedMemory.sv
`timescale 1ns/1ps
`default_nettype none

module unifiedMemory #(
    parameter int memWords = 1024
) (
    input  logic                 clock,
    input  logic                 rst,
    input  mipsPkg::wordT        instrAddr,
    output mipsPkg::wordT        instrData,
    input  mipsPkg::wordT        dataAddr,
    input  logic                 dataWrite,
    input  mipsPkg::wordT        dataWdata,
    output mipsPkg::wordT        dataRdata,
    input  logic                 loadEn,
    input  mipsPkg::wordT        loadAddr,
    input  mipsPkg::wordT        loadData,
    input  mipsPkg::wordT        peekAddr,
    output mipsPkg::wordT        peekData
);

    localparam int addrBits = $clog2(memWords);

    mipsPkg::wordT mem [memWords];

    // Program and data share one array, only the low address bits are decoded
    assign instrData = mem[instrAddr[addrBits-1:0]];
    assign dataRdata = mem[dataAddr[addrBits-1:0]];
    assign peekData = mem[peekAddr[addrBits-1:0]];

    // The host port fills memory while the core sits in reset
    always_ff @(posedge clock) begin
        if (loadEn) begin
            mem[loadAddr[addrBits-1:0]] <= loadData;
        end else if (dataWrite) begin
            mem[dataAddr[addrBits-1:0]] <= dataWdata;
        end
    end

    // Host loads must never race a running pipeline
    loadOnlyInReset: assert property (@(posedge clock) loadEn |-> rst);

endmodule

`default_nettype wire

//--- verilog/mips32Core.sv
`timescale 1ns/1ps
`default_nettype none

module mips32Core #(
    parameter int memWords = 1024
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 loadEn,
    input  mipsPkg::wordT        loadAddr,
    input  mipsPkg::wordT        loadData,
    input  mipsPkg::wordT        peekAddr,
    output mipsPkg::wordT        peekData,
    output logic                 halted
);

    // Pipeline registers between stages
    mipsPkg::ifIdT ifId;
    mipsPkg::idExT idEx;
    mipsPkg::exMemT exMem;
    mipsPkg::wbWriteT wbWrite;

    // Hazard and branch control
    logic stall;
    logic redirect;
    mipsPkg::wordT redirectTarget;

    // Register file read ports
    mipsPkg::regAddrT rsAddr;
    mipsPkg::regAddrT rtAddr;
    mipsPkg::wordT rsData;
    mipsPkg::wordT rtData;

    // Memory ports
    mipsPkg::wordT instrAddr;
    mipsPkg::wordT instrData;
    mipsPkg::wordT dataAddr;
    logic dataWrite;
    mipsPkg::wordT dataWdata;
    mipsPkg::wordT dataRdata;

    fetchStage #(.memWords(memWords)) fetch (
        .clock, .rst, .halted, .stall, .redirect, .redirectTarget,
        .instrAddr, .instrData, .ifId
    );

    regFile regs (
        .clock, .rst, .rsAddr, .rtAddr, .rsData, .rtData, .wbWrite
    );

    decodeStage decode (
        .clock, .rst, .halted, .redirect, .ifId,
        .rsAddr, .rtAddr, .rsData, .rtData, .stall, .idEx
    );

    executeStage execute (
        .clock, .rst, .halted, .idEx, .wbWrite, .redirect, .redirectTarget, .exMem
    );

    memWriteback memWb (
        .clock, .rst, .exMem, .dataAddr, .dataWrite, .dataWdata, .dataRdata,
        .wbWrite, .halted
    );

    unifiedMemory #(.memWords(memWords)) memory (
        .clock, .rst, .instrAddr, .instrData, .dataAddr, .dataWrite, .dataWdata,
        .dataRdata, .loadEn, .loadAddr, .loadData, .peekAddr, .peekData
    );

endmodule

`default_nettype wire

//--- tb/mipsProgram.svh
`ifndef MIPS_PROGRAM_SVH
`define MIPS_PROGRAM_SVH

// Memory map shared by every generated program
localparam int memWords = 1024;
localparam int progLen = 40;
// Thirty-one register dump stores plus the closing HLT
localparam int dumpLen = 32;
localparam int storeBase = 512;
localparam int dataBase = 768;
localparam int dumpBase = 960;

integer seed = 88;

// Host copy of memory, then the state of the sequential model
mipsPkg::wordT image [memWords];
mipsPkg::wordT modelMem [memWords];
mipsPkg::wordT modelRegs [32];

function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// Register form: opcode, rs, rt, rd and eleven unused bits
function automatic mipsPkg::wordT encodeReg(input mipsPkg::opcodeT op, input int rs,
                                            input int rt, input int rd);
    return {op, mipsPkg::regAddrT'(rs), mipsPkg::regAddrT'(rt), mipsPkg::regAddrT'(rd), 11'd0};
endfunction

// Immediate form: opcode, rs, rt and a 16-bit immediate
function automatic mipsPkg::wordT encodeImm(input mipsPkg::opcodeT op, input int rs,
                                            input int rt, input int imm);
    return {op, mipsPkg::regAddrT'(rs), mipsPkg::regAddrT'(rt), 16'(imm)};
endfunction

task automatic generateProgram();
    mipsPkg::opcodeT op;
    int useReg;
    int rt;
    int off;
    logic pendingUse;
    pendingUse = 1'b0;
    useReg = 0;
    for (int a = 0; a < progLen; a++) begin
        if (pendingUse) begin
            // Read the loaded register right away so the pipeline has to stall
            image[a] = encodeReg(mipsPkg::ADD, useReg, randBelow(8), 1 + randBelow(7));
            pendingUse = 1'b0;
        end else begin
            case (randBelow(10))
                0, 1, 2: begin
                    case (randBelow(5))
                        0: op = mipsPkg::ADD;
                        1: op = mipsPkg::SUB;
                        2: op = mipsPkg::AND;
                        3: op = mipsPkg::OR;
                        default: op = mipsPkg::SLT;
                    endcase
                    // Small register set keeps operands dependent on recent results
                    image[a] = encodeReg(op, randBelow(8), randBelow(8), randBelow(8));
                end
                3, 4, 5: begin
                    case (randBelow(3))
                        0: op = mipsPkg::ADDI;
                        1: op = mipsPkg::SUBI;
                        default: op = mipsPkg::SLTI;
                    endcase
                    // Full 16-bit range, so half the immediates are negative
                    image[a] = encodeImm(op, randBelow(8), randBelow(8), randBelow(65536));
                end
                6: begin
                    rt = 1 + randBelow(7);
                    image[a] = encodeImm(mipsPkg::LW, 0, rt, dataBase + randBelow(256));
                    pendingUse = randBelow(2) == 0;
                    useReg = rt;
                end
                7: begin
                    image[a] = encodeImm(mipsPkg::SW, 0, randBelow(8), storeBase + randBelow(256));
                end
                default: begin
                    // Forward skip of up to three words that never leaves the program
                    off = randBelow(4);
                    if (off > progLen - 1 - a) begin
                        off = progLen - 1 - a;
                    end
                    op = (randBelow(2) == 0) ? mipsPkg::BEQZ : mipsPkg::BNEQZ;
                    image[a] = encodeImm(op, randBelow(8), 0, off);
                end
            endcase
        end
    end
    // Dump r1 to r31 where the host can peek them, then stop
    for (int r = 1; r < 32; r++) begin
        image[progLen + r - 1] = encodeImm(mipsPkg::SW, 0, r, dumpBase + r);
    end
    image[progLen + dumpLen - 1] = encodeImm(mipsPkg::HLT, 0, 0, 0);
    // Store area gets a pattern tied to each address, load area gets random words
    for (int a = storeBase; a < dataBase; a++) begin
        image[a] = (mipsPkg::wordT'(a) * 32'h9E37_79B1) ^ 32'h00C0_FFEE;
    end
    for (int a = dataBase; a < memWords; a++) begin
        image[a] = $random(seed);
    end
endtask

// One instruction at a time, each finishing before the next starts
task automatic runModel();
    mipsPkg::wordT instr;
    mipsPkg::wordT a;
    mipsPkg::wordT b;
    mipsPkg::wordT imm;
    mipsPkg::wordT result;
    int pc;
    int dest;
    int steps;
    logic running;
    for (int i = 0; i < memWords; i++) begin
        modelMem[i] = image[i];
    end
    for (int r = 0; r < 32; r++) begin
        modelRegs[r] = '0;
    end
    pc = 0;
    steps = 0;
    running = 1'b1;
    while (running && steps < 4 * (progLen + dumpLen)) begin
        instr = modelMem[pc % memWords];
        // r0 is never written, so it always reads zero here
        a = modelRegs[int'(instr[25:21])];
        b = modelRegs[int'(instr[20:16])];
        imm = {{16{instr[15]}}, instr[15:0]};
        dest = 0;
        result = '0;
        pc = pc + 1;
        steps = steps + 1;
        case (mipsPkg::opcodeT'(instr[31:26]))
            mipsPkg::ADD: begin
                dest = int'(instr[15:11]);
                result = a + b;
            end
            mipsPkg::SUB: begin
                dest = int'(instr[15:11]);
                result = a - b;
            end
            mipsPkg::AND: begin
                dest = int'(instr[15:11]);
                result = a & b;
            end
            mipsPkg::OR: begin
                dest = int'(instr[15:11]);
                result = a | b;
            end
            mipsPkg::SLT: begin
                dest = int'(instr[15:11]);
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            mipsPkg::ADDI: begin
                dest = int'(instr[20:16]);
                result = a + imm;
            end
            mipsPkg::SUBI: begin
                dest = int'(instr[20:16]);
                result = a - imm;
            end
            mipsPkg::SLTI: begin
                dest = int'(instr[20:16]);
                result = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            end
            mipsPkg::LW: begin
                dest = int'(instr[20:16]);
                result = modelMem[int'((a + imm) % memWords)];
            end
            mipsPkg::SW: modelMem[int'((a + imm) % memWords)] = b;
            // pc already points one past the branch
            mipsPkg::BEQZ: if (a == '0) pc = pc + int'(imm);
            mipsPkg::BNEQZ: if (a != '0) pc = pc + int'(imm);
            mipsPkg::HLT: running = 1'b0;
            default: result = '0;
        endcase
        if (dest != 0) begin
            modelRegs[dest] = result;
        end
    end
endtask

`endif

//--- tb/mips32Tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips32Tb;

    localparam int clockPeriod = 8;
    localparam int resetCycles = 4;
    localparam int numPrograms = 20;
    localparam int holdCycles = 20;

    `include "mipsProgram.svh"

    // Cycle budget of one program covers reset, host load, run and the peek checks
    localparam int loadWords = progLen + dumpLen + (memWords - storeBase);
    localparam int runBudget = progLen * 4 + 60;
    localparam int checkCycles = (memWords - storeBase) + holdCycles + dumpLen;
    localparam int cyclesPerProgram = resetCycles + loadWords + runBudget + checkCycles + 16;
    localparam longint watchdogNs = longint'(numPrograms) * cyclesPerProgram * clockPeriod;

    logic clock = 1'b0;
    logic rst;
    logic loadEn;
    mipsPkg::wordT loadAddr;
    mipsPkg::wordT loadData;
    mipsPkg::wordT peekAddr;
    mipsPkg::wordT peekData;
    logic halted;

    int wordErrors = 0;
    int haltErrors = 0;
    int timeoutErrors = 0;

    mips32Core #(.memWords(memWords)) uut (
        .clock, .rst, .loadEn, .loadAddr, .loadData, .peekAddr, .peekData, .halted
    );

    always #(clockPeriod / 2) clock = ~clock;

    task automatic checkWord(input string name, input mipsPkg::wordT got,
                             input mipsPkg::wordT expected);
        if (got !== expected) begin
            wordErrors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic checkHalted(input logic expected);
        if (halted !== expected) begin
            haltErrors++;
            $display("CHECK FAILED halted: got %h, expected %h", halted, expected);
        end
    endtask

    task automatic loadWord(input int addr);
        @(posedge clock);
        loadEn <= 1'b1;
        loadAddr <= mipsPkg::wordT'(addr);
        loadData <= image[addr];
    endtask

    // The whole host load happens with the core held in reset
    task automatic resetAndLoad();
        @(posedge clock);
        rst <= 1'b1;
        repeat (resetCycles) @(posedge clock);
        @(negedge clock);
        checkHalted(1'b0);
        for (int a = 0; a < progLen + dumpLen; a++) begin
            loadWord(a);
        end
        for (int a = storeBase; a < memWords; a++) begin
            loadWord(a);
        end
        @(posedge clock);
        loadEn <= 1'b0;
        @(negedge clock);
        checkHalted(1'b0);
        @(posedge clock);
        rst <= 1'b0;
    endtask

    task automatic waitForHalt(input int prog, output logic finished);
        int cycles;
        finished = 1'b0;
        cycles = 0;
        while (!finished && cycles < runBudget) begin
            @(negedge clock);
            cycles++;
            finished = halted;
        end
        if (!finished) begin
            timeoutErrors++;
            $display("Program %0d did not halt within %0d cycles", prog, runBudget);
        end
    endtask

    // The address goes out on the rising edge and the data is read half a cycle later
    task automatic peekWord(input int addr, output mipsPkg::wordT value);
        @(posedge clock);
        peekAddr <= mipsPkg::wordT'(addr);
        @(negedge clock);
        value = peekData;
    endtask

    task automatic checkResults();
        mipsPkg::wordT value;
        for (int a = storeBase; a < memWords; a++) begin
            peekWord(a, value);
            checkHalted(1'b1);
            // The dump words carry the final registers
            if (a > dumpBase && a < dumpBase + 32) begin
                checkWord($sformatf("r%0d", a - dumpBase), value, modelRegs[a - dumpBase]);
            end else begin
                checkWord($sformatf("mem[%0d]", a), value, modelMem[a]);
            end
        end
        repeat (holdCycles) begin
            @(negedge clock);
            checkHalted(1'b1);
        end
        // A halted core must not touch memory any more
        for (int a = dumpBase + 1; a < dumpBase + 32; a++) begin
            peekWord(a, value);
            checkWord($sformatf("held r%0d", a - dumpBase), value, modelRegs[a - dumpBase]);
        end
    endtask

    initial begin
        logic finished;
        rst <= 1'b1;
        loadEn <= 1'b0;
        loadAddr <= '0;
        loadData <= '0;
        peekAddr <= '0;
        for (int prog = 0; prog < numPrograms; prog++) begin
            generateProgram();
            runModel();
            resetAndLoad();
            waitForHalt(prog, finished);
            if (finished) begin
                checkResults();
            end
        end
        $display("Errors: word %0d, halted %0d, timeout %0d",
                 wordErrors, haltErrors, timeoutErrors);
        if (wordErrors + haltErrors + timeoutErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // The watchdog bounds the whole run in case a wait never ends
    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns, the run is stuck", watchdogNs);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+tb
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memWriteback.sv
verilog/unifiedMemory.sv
verilog/mips32Core.sv
tb/mips32Tb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mips32Tb -f list.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
    exit 0
fi
exit 1
